// File: Bender.yml
package:
  name: atom_glue

sources:
  - atom_glue_pkg.sv
  - sys_control.sv
  - bus_phase_sequencer.sv
  - byte_store.sv
  - option_router.sv
  - atom_glue_top.sv
  - target: test
    files:
      - atom_glue_checker.sv
      - tb_atom_glue.sv

// File: atom_glue_checker.sv
module atom_glue_checker (
    input  logic                  clk_42,
    input  logic                  reset,
    input  logic                  cpuphi2,
    input  logic                  rd_check,
    input  atom_glue_pkg::byte_t  exp_dout,
    input  atom_glue_pkg::byte_t  mem_dout,
    input  logic                  exp_core_reset,
    input  logic                  core_reset,
    input  logic                  pixel_ce,
    input  logic [63:0]           exp_joy,
    input  atom_glue_pkg::joy_t   joya,
    input  atom_glue_pkg::joy_t   joyb,
    input  atom_glue_pkg::audio_t exp_audio,
    input  atom_glue_pkg::audio_t audio,
    output int                    checks,
    output int                    errors
);
    import atom_glue_pkg::*;

    logic        primed = 1'b0;
    logic        reset_q = 1'b1;
    logic        phi2_q = 1'b0;
    logic        exp_core_reset_q;
    logic [63:0] exp_joy_q;
    audio_t      exp_audio_q;
    int          ce_count = 0;

    initial begin
        checks = 0;
        errors = 0;
    end

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // registered outputs trail the inputs seen on the previous falling edge
    always @(negedge clk_42) begin
        if (reset_q) begin
            ce_count = 0;
        end else begin
            ce_count = ce_count + 1;
        end
        if (primed) begin
            compare("core_reset", exp_core_reset_q, core_reset);
            compare("joya", exp_joy_q[63:32], joya);
            compare("joyb", exp_joy_q[31:0], joyb);
            compare("audio", exp_audio_q, audio);
            // first pulse on the third edge out of reset
            compare("pixel_ce", !reset_q && (ce_count % 3 == 0), pixel_ce);
        end
        // read data is due by the next phi2 rise
        if (cpuphi2 && !phi2_q && rd_check) begin
            compare("mem_dout", exp_dout, mem_dout);
        end
        primed           <= 1'b1;
        reset_q          <= reset;
        phi2_q           <= cpuphi2;
        exp_core_reset_q <= exp_core_reset;
        exp_joy_q        <= exp_joy;
        exp_audio_q      <= exp_audio;
    end

endmodule

// File: atom_glue_pkg.sv
package atom_glue_pkg;

    ///////////////////////////////////////////////////////////////////////
    // widths
    ///////////////////////////////////////////////////////////////////////

    localparam int MEM_ADDR_W = 18;
    localparam int PHASE_W    = 5;
    localparam int AUDIO_W    = 16;
    localparam int SID_W      = 18;
    localparam int JOY_W      = 32;
    localparam int STATUS_W   = 32;

    // bus phases within one cpu cycle, counted from the phi2 rising edge
    localparam int PHASE_READ    = 16;
    localparam int PHASE_CAPTURE = 20;
    localparam int PHASE_WRITE   = 31;

    // 42.95 MHz down to the 14.318 MHz pixel rate
    localparam int CE_DIV = 3;

    localparam int READ_LATENCY = 2;

    // osd status bits
    localparam int STATUS_RESET_BIT = 0;
    localparam int STATUS_SWAP_BIT  = 3;
    localparam int STATUS_AUDIO_LSB = 4;

    // audio source codes
    localparam logic [1:0] AUDIO_SEL_ATOM = 2'd0;
    localparam logic [1:0] AUDIO_SEL_SID  = 2'd1;
    localparam logic [1:0] AUDIO_SEL_TAPE = 2'd2;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [7:0]            byte_t;
    typedef logic [PHASE_W-1:0]    phase_t;
    typedef logic [AUDIO_W-1:0]    audio_t;
    typedef logic [SID_W-1:0]      sid_sample_t;
    typedef logic [JOY_W-1:0]      joy_t;
    typedef logic [STATUS_W-1:0]   status_t;
    typedef logic [1:0]            audio_sel_t;

endpackage

// File: atom_glue_top.sv
module atom_glue_top (
    input  logic                       clk_42,
    input  logic                       reset,
    input  atom_glue_pkg::status_t     status,
    input  logic [1:0]                 buttons,
    input  logic                       pll_locked,
    input  logic                       ioctl_download,
    input  atom_glue_pkg::byte_t       ioctl_index,
    input  logic                       ioctl_wr,
    input  atom_glue_pkg::mem_addr_t   ioctl_addr,
    input  atom_glue_pkg::byte_t       ioctl_dout,
    input  logic                       cpuphi2,
    input  atom_glue_pkg::mem_addr_t   mem_addr,
    input  logic                       mem_we,
    input  atom_glue_pkg::byte_t       mem_din,
    input  atom_glue_pkg::joy_t        joy0,
    input  atom_glue_pkg::joy_t        joy1,
    input  logic                       atom_audio,
    input  atom_glue_pkg::sid_sample_t sid_audio,
    input  logic                       tape_out,
    output logic                       core_reset,
    output logic                       pixel_ce,
    output atom_glue_pkg::byte_t       mem_dout,
    output atom_glue_pkg::joy_t        joya,
    output atom_glue_pkg::joy_t        joyb,
    output atom_glue_pkg::audio_t      audio
);
    import atom_glue_pkg::*;

    // sequencer to byte store
    mem_addr_t store_addr;
    byte_t     store_din;
    byte_t     store_dout;
    logic      store_rd;
    logic      store_we;
    logic      store_ready;

    sys_control u_sys_control (
        .clk_42         (clk_42),
        .reset          (reset),
        .status         (status),
        .buttons        (buttons),
        .ioctl_download (ioctl_download),
        .pll_locked     (pll_locked),
        .core_reset     (core_reset),
        .pixel_ce       (pixel_ce)
    );

    bus_phase_sequencer u_bus_phase_sequencer (
        .clk_42         (clk_42),
        .reset          (reset),
        .cpuphi2        (cpuphi2),
        .mem_addr       (mem_addr),
        .mem_we         (mem_we),
        .mem_din        (mem_din),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .store_dout     (store_dout),
        .store_addr     (store_addr),
        .store_din      (store_din),
        .store_rd       (store_rd),
        .store_we       (store_we),
        .mem_dout       (mem_dout)
    );

    // ready left unused by the sequencer, fixed latency covers it
    byte_store u_byte_store (
        .clk_42      (clk_42),
        .reset       (reset),
        .store_addr  (store_addr),
        .store_din   (store_din),
        .store_rd    (store_rd),
        .store_we    (store_we),
        .store_dout  (store_dout),
        .store_ready (store_ready)
    );

    option_router u_option_router (
        .clk_42     (clk_42),
        .reset      (reset),
        .status     (status),
        .joy0       (joy0),
        .joy1       (joy1),
        .atom_audio (atom_audio),
        .sid_audio  (sid_audio),
        .tape_out   (tape_out),
        .joya       (joya),
        .joyb       (joyb),
        .audio      (audio)
    );

endmodule

// File: bus_phase_sequencer.sv
module bus_phase_sequencer (
    input  logic                     clk_42,
    input  logic                     reset,
    input  logic                     cpuphi2,
    input  atom_glue_pkg::mem_addr_t mem_addr,
    input  logic                     mem_we,
    input  atom_glue_pkg::byte_t     mem_din,
    input  logic                     ioctl_download,
    input  atom_glue_pkg::byte_t     ioctl_index,
    input  logic                     ioctl_wr,
    input  atom_glue_pkg::mem_addr_t ioctl_addr,
    input  atom_glue_pkg::byte_t     ioctl_dout,
    input  atom_glue_pkg::byte_t     store_dout,
    output atom_glue_pkg::mem_addr_t store_addr,
    output atom_glue_pkg::byte_t     store_din,
    output logic                     store_rd,
    output logic                     store_we,
    output atom_glue_pkg::byte_t     mem_dout
);
    import atom_glue_pkg::*;

    logic   cpuphi2_last;
    phase_t phase;
    logic   phi2_rise;
    logic   dl_active;
    logic   dl_wr;

    assign phi2_rise = cpuphi2 & ~cpuphi2_last;

    // odd index is a cartridge image, not for this memory
    assign dl_active = ioctl_download & ~ioctl_index[0];
    assign dl_wr     = dl_active & ioctl_wr;

    ///////////////////////////////////////////////////////////////////////
    // phase counter
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_42) begin
        if (reset) begin
            cpuphi2_last <= 1'b0;
            phase        <= '0;
        end else begin
            cpuphi2_last <= cpuphi2;
            if (phi2_rise) begin
                phase <= '0;
            end else begin
                // wraps after 31
                phase <= phase + 1'b1;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // address and data source
    ///////////////////////////////////////////////////////////////////////

    // address holds during an ignored download
    always_ff @(posedge clk_42) begin
        if (dl_active) begin
            store_addr <= ioctl_addr;
        end else if (!ioctl_download) begin
            store_addr <= mem_addr;
        end

        if (dl_wr) begin
            store_din <= ioctl_dout;
        end else if (!ioctl_download && mem_we) begin
            store_din <= mem_din;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // strobes and read capture
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_42) begin
        if (reset) begin
            store_rd <= 1'b0;
            store_we <= 1'b0;
        end else begin
            store_rd <= (phase == PHASE_READ) & ~ioctl_download & ~mem_we;
            // cpu is held in reset while a download owns the memory
            store_we <= dl_wr | ((phase == PHASE_WRITE) & mem_we & ~ioctl_download);
        end
    end

    // capture slot sits after the store latency, so ready is not needed
    always_ff @(posedge clk_42) begin
        if (phase == PHASE_CAPTURE) begin
            mem_dout <= store_dout;
        end
    end

endmodule

// File: byte_store.sv
module byte_store (
    input  logic                     clk_42,
    input  logic                     reset,
    input  atom_glue_pkg::mem_addr_t store_addr,
    input  atom_glue_pkg::byte_t     store_din,
    input  logic                     store_rd,
    input  logic                     store_we,
    output atom_glue_pkg::byte_t     store_dout,
    output logic                     store_ready
);
    import atom_glue_pkg::*;

    byte_t                   mem [2**MEM_ADDR_W];
    byte_t                   rd_data [READ_LATENCY];
    logic [READ_LATENCY-1:0] rd_pipe;

    always_ff @(posedge clk_42) begin
        if (store_we) begin
            mem[store_addr] <= store_din;
        end
    end

    // read pipeline, each stage moves only behind its own valid bit
    always_ff @(posedge clk_42) begin
        if (store_rd) begin
            rd_data[0] <= mem[store_addr];
        end
        for (int i = 1; i < READ_LATENCY; i++) begin
            if (rd_pipe[i-1]) begin
                rd_data[i] <= rd_data[i-1];
            end
        end
    end

    assign store_dout = rd_data[READ_LATENCY-1];

    ///////////////////////////////////////////////////////////////////////
    // valid tracking
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_42) begin
        if (reset) begin
            rd_pipe     <= '0;
            store_ready <= 1'b0;
        end else begin
            rd_pipe <= {rd_pipe[READ_LATENCY-2:0], store_rd};
            // ready drops on any new strobe
            if (store_rd || store_we) begin
                store_ready <= 1'b0;
            end else if (rd_pipe[READ_LATENCY-2]) begin
                store_ready <= 1'b1;
            end
        end
    end

endmodule

// File: list.f
atom_glue_pkg.sv
sys_control.sv
bus_phase_sequencer.sv
byte_store.sv
option_router.sv
atom_glue_top.sv
atom_glue_checker.sv
tb_atom_glue.sv

// File: option_router.sv
module option_router (
    input  logic                       clk_42,
    input  logic                       reset,
    input  atom_glue_pkg::status_t     status,
    input  atom_glue_pkg::joy_t        joy0,
    input  atom_glue_pkg::joy_t        joy1,
    input  logic                       atom_audio,
    input  atom_glue_pkg::sid_sample_t sid_audio,
    input  logic                       tape_out,
    output atom_glue_pkg::joy_t        joya,
    output atom_glue_pkg::joy_t        joyb,
    output atom_glue_pkg::audio_t      audio
);
    import atom_glue_pkg::*;

    logic       swap;
    audio_sel_t audio_sel;
    audio_t     audio_mux;

    assign swap      = status[STATUS_SWAP_BIT];
    assign audio_sel = status[STATUS_AUDIO_LSB +: 2];

    always_comb begin
        case (audio_sel)
            AUDIO_SEL_ATOM: audio_mux = {AUDIO_W{atom_audio}};
            AUDIO_SEL_SID:  audio_mux = sid_audio[SID_W-1 -: AUDIO_W];
            AUDIO_SEL_TAPE: audio_mux = {AUDIO_W{tape_out}};
            default:        audio_mux = '0;
        endcase
    end

    // core joystick inputs are active low
    always_ff @(posedge clk_42) begin
        if (reset) begin
            joya  <= '1;
            joyb  <= '1;
            audio <= '0;
        end else begin
            joya  <= swap ? ~joy1 : ~joy0;
            joyb  <= swap ? ~joy0 : ~joy1;
            audio <= audio_mux;
        end
    end

endmodule

// File: sys_control.sv
module sys_control (
    input  logic                   clk_42,
    input  logic                   reset,
    input  atom_glue_pkg::status_t status,
    input  logic [1:0]             buttons,
    input  logic                   ioctl_download,
    input  logic                   pll_locked,
    output logic                   core_reset,
    output logic                   pixel_ce
);
    import atom_glue_pkg::*;

    logic [1:0] ce_count;

    ///////////////////////////////////////////////////////////////////////
    // core reset
    ///////////////////////////////////////////////////////////////////////

    // any cause holds the core, including a running rom download
    always_ff @(posedge clk_42) begin
        core_reset <= reset
                    | status[STATUS_RESET_BIT]
                    | buttons[1]
                    | ioctl_download
                    | ~pll_locked;
    end

    ///////////////////////////////////////////////////////////////////////
    // pixel clock enable
    ///////////////////////////////////////////////////////////////////////

    // one pulse every CE_DIV cycles, first one on the third edge after reset
    always_ff @(posedge clk_42) begin
        if (reset) begin
            ce_count <= '0;
            pixel_ce <= 1'b0;
        end else if (ce_count == 2'(CE_DIV - 1)) begin
            ce_count <= '0;
            pixel_ce <= 1'b1;
        end else begin
            ce_count <= ce_count + 2'd1;
            pixel_ce <= 1'b0;
        end
    end

endmodule

// File: tb_atom_glue.sv
module tb_atom_glue;
    import atom_glue_pkg::*;

    // about three times the download plus 150 bus cycles
    localparam int CYCLE_LIMIT = 20000;

    logic        clk_42 = 1'b0;
    logic        reset = 1'b1;
    status_t     status = '0;
    logic [1:0]  buttons = '0;
    logic        pll_locked = 1'b1;
    logic        ioctl_download = 1'b0;
    byte_t       ioctl_index = '0;
    logic        ioctl_wr = 1'b0;
    mem_addr_t   ioctl_addr = '0;
    byte_t       ioctl_dout = '0;
    logic        cpuphi2 = 1'b0;
    mem_addr_t   mem_addr = '0;
    logic        mem_we = 1'b0;
    byte_t       mem_din = '0;
    joy_t        joy0 = '0;
    joy_t        joy1 = '0;
    logic        atom_audio = 1'b0;
    sid_sample_t sid_audio = '0;
    logic        tape_out = 1'b0;
    logic        core_reset, pixel_ce;
    byte_t       mem_dout;
    joy_t        joya, joyb;
    audio_t      audio;

    logic        phi2_last = 1'b0;
    logic        rd_check = 1'b0;
    byte_t       exp_dout = '0;
    logic        exp_core_reset;
    logic [63:0] exp_joy;
    audio_t      exp_audio;
    int          cycle_count = 0;
    int          checks;
    int          errors;
    integer      seed = 32'h113f5fbb;
    byte_t       model [2**MEM_ADDR_W];
    mem_addr_t   known [$];

    ///////////////////////////////////////////////////////////////////////
    // reference model
    ///////////////////////////////////////////////////////////////////////

    function automatic logic core_reset_ref(input logic rst, input status_t st,
                                            input logic [1:0] btn, input logic dl,
                                            input logic locked);
        return rst | st[STATUS_RESET_BIT] | btn[1] | dl | ~locked;
    endfunction

    // {joya, joyb}, active low towards the core
    function automatic logic [63:0] joy_ref(input logic rst, input status_t st,
                                            input joy_t j0, input joy_t j1);
        if (rst) begin
            return '1;
        end
        return st[STATUS_SWAP_BIT] ? {~j1, ~j0} : {~j0, ~j1};
    endfunction

    function automatic audio_t audio_ref(input logic rst, input status_t st, input logic beep,
                                         input sid_sample_t sid, input logic tape);
        if (rst) begin
            return '0;
        end
        case (st[STATUS_AUDIO_LSB +: 2])
            2'd0:    return {16{beep}};
            2'd1:    return sid[17:2];
            2'd2:    return {16{tape}};
            default: return '0;
        endcase
    endfunction

    assign exp_core_reset = core_reset_ref(reset, status, buttons, ioctl_download, pll_locked);
    assign exp_joy        = joy_ref(reset, status, joy0, joy1);
    assign exp_audio      = audio_ref(reset, status, atom_audio, sid_audio, tape_out);

    atom_glue_top u_atom_glue_top (.*);

    atom_glue_checker u_atom_glue_checker (.*);

    always #50 clk_42 = ~clk_42;

    // phi2 every 16 cycles and the cycle cap
    always @(posedge clk_42) begin
        cycle_count <= cycle_count + 1;
        phi2_last   <= cpuphi2;
        if (cycle_count % 16 == 15) begin
            cpuphi2 <= ~cpuphi2;
        end
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // stimulus
    ///////////////////////////////////////////////////////////////////////

    task automatic download(input byte_t index, input mem_addr_t base, input int count);
        byte_t data;
        for (int i = 0; i < count; i++) begin
            data = byte_t'($random(seed));
            @(posedge clk_42);
            ioctl_download <= 1'b1;
            ioctl_index    <= index;
            ioctl_wr       <= 1'b1;
            ioctl_addr     <= base + mem_addr_t'(i);
            ioctl_dout     <= data;
            // odd index is a cartridge and leaves memory alone
            if (!index[0]) begin
                model[base + mem_addr_t'(i)] = data;
                known.push_back(base + mem_addr_t'(i));
            end
            @(posedge clk_42);
            ioctl_wr <= 1'b0;
        end
        @(posedge clk_42);
        ioctl_download <= 1'b0;
    endtask

    // one bus cycle, driven from the edge that first sees phi2 high
    task automatic cpu_cycle(input mem_addr_t addr, input logic we, input byte_t data,
                             input logic check);
        @(posedge clk_42);
        while (!(cpuphi2 && !phi2_last)) begin
            @(posedge clk_42);
        end
        mem_addr <= addr;
        mem_we   <= we;
        mem_din  <= data;
        rd_check <= check;
        exp_dout <= model[addr];
        if (we) begin
            model[addr] = data;
        end
    endtask

    initial begin
        status_t   st;
        mem_addr_t dl_base;
        mem_addr_t a;
        repeat (4) @(posedge clk_42);
        reset <= 1'b0;
        repeat (20) @(posedge clk_42);

        // fill memory and try a cartridge over it
        dl_base = mem_addr_t'($random(seed));
        download(8'h00, dl_base, 64);
        download(8'h01, dl_base, 16);

        for (int n = 0; n < 150; n++) begin
            if ($random(seed) & 1) begin
                a = dl_base + mem_addr_t'($unsigned($random(seed)) % 128);
                known.push_back(a);
                cpu_cycle(a, 1'b1, byte_t'($random(seed)), 1'b0);
            end else begin
                a = known[$unsigned($random(seed)) % known.size()];
                cpu_cycle(a, 1'b0, 8'h00, 1'b1);
            end
        end
        cpu_cycle('0, 1'b0, 8'h00, 1'b0);

        // option routing and reset causes, audio code stepped in turn
        for (int n = 0; n < 200; n++) begin
            st = $random(seed);
            st[STATUS_AUDIO_LSB +: 2] = 2'(n);
            @(posedge clk_42);
            status         <= st;
            buttons        <= 2'($random(seed));
            pll_locked     <= ($random(seed) & 7) != 0;
            ioctl_download <= ($random(seed) & 7) == 0;
            reset          <= ($random(seed) & 31) == 0;
            joy0           <= $random(seed);
            joy1           <= $random(seed);
            atom_audio     <= 1'($random(seed));
            sid_audio      <= 18'($random(seed));
            tape_out       <= 1'($random(seed));
        end
        @(posedge clk_42);
        reset <= 1'b0;
        repeat (4) @(posedge clk_42);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
